/* rv_pkg.sv */
`default_nettype none

package rv_pkg;

	// ------------------------------------------------------------------------
	// Widths
	// ------------------------------------------------------------------------

	typedef logic [63:0] xlen_t;    // Register and data word.
	typedef logic [31:0] instr_t;   // Instruction word.
	typedef logic [4:0]  reg_idx_t; // Register index.
	typedef logic [6:0]  opcode_t;  // Major opcode.
	typedef logic [2:0]  funct3_t;  // Minor function.

	localparam int xlen = $bits(xlen_t);

	// ------------------------------------------------------------------------
	// Major opcodes
	// ------------------------------------------------------------------------

	localparam opcode_t op_lui       = 7'b0110111;
	localparam opcode_t op_auipc     = 7'b0010111;
	localparam opcode_t op_jal       = 7'b1101111;
	localparam opcode_t op_jalr      = 7'b1100111;
	localparam opcode_t op_branch    = 7'b1100011;
	localparam opcode_t op_load      = 7'b0000011; // Decoded for format only.
	localparam opcode_t op_store     = 7'b0100011;
	localparam opcode_t op_op_imm    = 7'b0010011;
	localparam opcode_t op_op        = 7'b0110011;
	localparam opcode_t op_op_imm_32 = 7'b0011011;
	localparam opcode_t op_op_32     = 7'b0111011;
	localparam opcode_t op_system    = 7'b1110011; // Decoded for format only.

	// ------------------------------------------------------------------------
	// Operand selects
	// ------------------------------------------------------------------------

	typedef enum logic {
		V1_RS1, // First source register.
		V1_PC   // Instruction address.
	} v1_sel_e;

	typedef enum logic {
		V2_RS2, // Second source register.
		V2_IMM  // Sign-extended immediate.
	} v2_sel_e;

	// ------------------------------------------------------------------------
	// Decoded instruction
	// ------------------------------------------------------------------------

	typedef struct packed {
		opcode_t  opcode;
		funct3_t  func3;
		logic     func7_bit; // Instruction bit 30.
		reg_idx_t rs1;
		reg_idx_t rs2;
		reg_idx_t rd;
		xlen_t    imm;
		v1_sel_e  v1_sel;
		v2_sel_e  v2_sel;
		logic     mul;       // M-extension multiply.
	} decoded_t;

endpackage

`default_nettype wire

/* rv_decode.sv */
`default_nettype none

module rv_decode (
	input  rv_pkg::instr_t   instr,
	output rv_pkg::decoded_t dec
);

	rv_pkg::opcode_t opcode;
	logic            i_type;
	logic            u_type;
	logic            j_type;
	logic            b_type;
	logic            s_type;
	logic            r_type;
	rv_pkg::xlen_t   imm;

	assign opcode = instr[6:0];

	// ------------------------------------------------------------------------
	// Format classification
	// ------------------------------------------------------------------------

	assign i_type = (opcode == rv_pkg::op_jalr)
		| (opcode == rv_pkg::op_load)
		| (opcode == rv_pkg::op_op_imm)
		| (opcode == rv_pkg::op_op_imm_32)
		| (opcode == rv_pkg::op_system);
	assign u_type = (opcode == rv_pkg::op_lui) | (opcode == rv_pkg::op_auipc);
	assign j_type = (opcode == rv_pkg::op_jal);
	assign b_type = (opcode == rv_pkg::op_branch);
	assign s_type = (opcode == rv_pkg::op_store);
	assign r_type = (opcode == rv_pkg::op_op) | (opcode == rv_pkg::op_op_32);

	// ------------------------------------------------------------------------
	// Immediate assembly
	// ------------------------------------------------------------------------

	always_comb begin
		if (i_type) begin
			imm = {{52{instr[31]}}, instr[31:20]};
		end else if (u_type) begin
			imm = {{32{instr[31]}}, instr[31:12], 12'b0};
		end else if (j_type) begin
			imm = {{44{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
		end else if (b_type) begin
			imm = {{52{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
		end else if (s_type) begin
			imm = {{52{instr[31]}}, instr[31:25], instr[11:7]};
		end else begin
			imm = '0; // R-type has no immediate.
		end
	end

	// ------------------------------------------------------------------------
	// Decoded fields
	// ------------------------------------------------------------------------

	always_comb begin
		dec.opcode    = opcode;
		dec.func3     = instr[14:12];
		dec.func7_bit = instr[30];
		dec.rs1       = u_type ? '0 : instr[19:15];
		dec.rs2       = (i_type | u_type) ? '0 : instr[24:20];
		dec.rd        = (s_type | b_type) ? '0 : instr[11:7]; // No write-back.
		dec.imm       = imm;

		if (j_type || opcode == rv_pkg::op_auipc) begin
			dec.v1_sel = rv_pkg::V1_PC;
		end else begin
			dec.v1_sel = rv_pkg::V1_RS1;
		end

		if (r_type || b_type) begin
			dec.v2_sel = rv_pkg::V2_RS2;
		end else begin
			dec.v2_sel = rv_pkg::V2_IMM;
		end

		dec.mul = r_type & instr[25]; // funct7 of 0000001.
	end

endmodule

`default_nettype wire

/* rv_regfile.sv */
`default_nettype none

module rv_regfile (
	input  logic             clock,
	input  logic             reset,
	input  logic             we,
	input  rv_pkg::reg_idx_t waddr,
	input  rv_pkg::xlen_t    wdata,
	input  rv_pkg::reg_idx_t raddr1,
	input  rv_pkg::reg_idx_t raddr2,
	output rv_pkg::xlen_t    rdata1,
	output rv_pkg::xlen_t    rdata2
);

	rv_pkg::xlen_t regs [1:31]; // x0 is not stored.

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	// Asynchronous reads.
	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

	// ------------------------------------------------------------------------
	// Checks
	// ------------------------------------------------------------------------

	a_write_lands: assert property (
		@(posedge clock) disable iff (reset)
		(we && waddr != '0) |=> (raddr1 != $past(waddr) || rdata1 == $past(wdata))
	) else $error("rv_regfile: read after write returned %h", rdata1);

endmodule

`default_nettype wire

/* rv_execute.sv */
`default_nettype none

module rv_execute (
	input  rv_pkg::decoded_t dec,
	input  rv_pkg::xlen_t    pc,
	input  rv_pkg::xlen_t    rs1_data,
	input  rv_pkg::xlen_t    rs2_data,
	output rv_pkg::xlen_t    result,
	output logic             taken,
	output rv_pkg::xlen_t    target
);

	localparam int shamt_w = $clog2(rv_pkg::xlen);

	rv_pkg::xlen_t        v1;
	rv_pkg::xlen_t        v2;
	rv_pkg::xlen_t        shift_src;
	rv_pkg::xlen_t        alu_out;
	rv_pkg::xlen_t        mul_out;
	rv_pkg::xlen_t        pc_plus4;
	logic [shamt_w-1:0]   shamt;
	logic                 word_op;
	logic                 imm_op;
	logic                 sub_en;
	logic                 sra_en;
	logic                 is_branch;
	logic                 is_jal;
	logic                 is_jalr;
	logic                 branch_cond;

	assign word_op   = (dec.opcode == rv_pkg::op_op_32) | (dec.opcode == rv_pkg::op_op_imm_32);
	assign imm_op    = (dec.opcode == rv_pkg::op_op_imm) | (dec.opcode == rv_pkg::op_op_imm_32);
	assign is_branch = (dec.opcode == rv_pkg::op_branch);
	assign is_jal    = (dec.opcode == rv_pkg::op_jal);
	assign is_jalr   = (dec.opcode == rv_pkg::op_jalr);

	// ------------------------------------------------------------------------
	// Operands
	// ------------------------------------------------------------------------

	assign v1 = (dec.v1_sel == rv_pkg::V1_PC) ? pc : rs1_data;
	assign v2 = (dec.v2_sel == rv_pkg::V2_IMM) ? dec.imm : rs2_data;

	// Bit 30 is part of the immediate for ADDI, so only shifts honor it there.
	assign sub_en = dec.func7_bit & ~imm_op;
	assign sra_en = dec.func7_bit;

	// W shifts use 5 bits and act on the low word.
	assign shamt = word_op ? {1'b0, v2[shamt_w-2:0]} : v2[shamt_w-1:0];

	always_comb begin
		if (!word_op) begin
			shift_src = v1;
		end else if (sra_en) begin
			shift_src = {{32{v1[31]}}, v1[31:0]};
		end else begin
			shift_src = {32'b0, v1[31:0]};
		end
	end

	// ------------------------------------------------------------------------
	// ALU and multiplier
	// ------------------------------------------------------------------------

	always_comb begin
		case (dec.func3)
			3'b000: alu_out = sub_en ? v1 - v2 : v1 + v2;
			3'b001: alu_out = v1 << shamt;
			3'b010: alu_out = {{(rv_pkg::xlen-1){1'b0}}, $signed(v1) < $signed(v2)};
			3'b011: alu_out = {{(rv_pkg::xlen-1){1'b0}}, v1 < v2};
			3'b100: alu_out = v1 ^ v2;
			3'b101: begin
				if (sra_en) begin
					alu_out = $signed(shift_src) >>> shamt;
				end else begin
					alu_out = shift_src >> shamt;
				end
			end
			3'b110: alu_out = v1 | v2;
			default: alu_out = v1 & v2;
		endcase
	end

	assign mul_out  = v1 * v2; // Low 64 bits only.
	assign pc_plus4 = pc + 64'd4;

	always_comb begin
		case (dec.opcode)
			rv_pkg::op_lui:   result = dec.imm;
			rv_pkg::op_auipc: result = v1 + v2;
			rv_pkg::op_jal,
			rv_pkg::op_jalr:  result = pc_plus4;
			rv_pkg::op_op,
			rv_pkg::op_op_imm: result = dec.mul ? mul_out : alu_out;
			rv_pkg::op_op_32,
			rv_pkg::op_op_imm_32: begin
				if (dec.mul) begin
					result = {{32{mul_out[31]}}, mul_out[31:0]};
				end else begin
					result = {{32{alu_out[31]}}, alu_out[31:0]};
				end
			end
			default: result = '0; // Stores and others write nothing.
		endcase
	end

	// ------------------------------------------------------------------------
	// Branch and jump resolution
	// ------------------------------------------------------------------------

	always_comb begin
		case (dec.func3)
			3'b000: branch_cond = (rs1_data == rs2_data);
			3'b001: branch_cond = (rs1_data != rs2_data);
			3'b100: branch_cond = $signed(rs1_data) < $signed(rs2_data);
			3'b101: branch_cond = $signed(rs1_data) >= $signed(rs2_data);
			3'b110: branch_cond = rs1_data < rs2_data;
			3'b111: branch_cond = rs1_data >= rs2_data;
			default: branch_cond = 1'b0;
		endcase
	end

	assign taken  = (is_branch & branch_cond) | is_jal | is_jalr;
	assign target = is_jalr ? ((rs1_data + dec.imm) & ~64'd1) : pc + dec.imm;

endmodule

`default_nettype wire

/* rv_exec_top.sv */
`default_nettype none

module rv_exec_top (
	input  logic             clock,
	input  logic             reset,
	input  logic             instr_valid,
	input  rv_pkg::instr_t   instr,
	input  rv_pkg::xlen_t    pc,
	output logic             wb_valid,
	output rv_pkg::reg_idx_t wb_rd,
	output rv_pkg::xlen_t    wb_data,
	output logic             branch_taken,
	output rv_pkg::xlen_t    branch_target
);

	rv_pkg::decoded_t dec;
	rv_pkg::xlen_t    rs1_data;
	rv_pkg::xlen_t    rs2_data;
	rv_pkg::xlen_t    result;
	rv_pkg::xlen_t    target;
	logic             taken;

	rv_decode u_decode (
		.instr (instr),
		.dec   (dec)
	);

	rv_regfile u_regfile (
		.clock  (clock),
		.reset  (reset),
		.we     (instr_valid), // Lands on the write-back edge.
		.waddr  (dec.rd),
		.wdata  (result),
		.raddr1 (dec.rs1),
		.raddr2 (dec.rs2),
		.rdata1 (rs1_data),
		.rdata2 (rs2_data)
	);

	rv_execute u_execute (
		.dec      (dec),
		.pc       (pc),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.result   (result),
		.taken    (taken),
		.target   (target)
	);

	// ------------------------------------------------------------------------
	// Write-back and branch outputs
	// ------------------------------------------------------------------------

	always_ff @(posedge clock) begin
		if (reset) begin
			wb_valid     <= 1'b0;
			branch_taken <= 1'b0;
		end else begin
			wb_valid     <= instr_valid;
			branch_taken <= instr_valid & taken;
		end
	end

	always_ff @(posedge clock) begin
		if (instr_valid) begin
			wb_rd         <= dec.rd;
			wb_data       <= result;
			branch_target <= target;
		end
	end

endmodule

`default_nettype wire

/* tb_rv_exec.sv */
`default_nettype none

module tb_rv_exec;

	logic             clock;
	logic             reset;
	logic             instr_valid;
	rv_pkg::instr_t   instr;
	rv_pkg::xlen_t    pc;
	logic             wb_valid;
	rv_pkg::reg_idx_t wb_rd;
	rv_pkg::xlen_t    wb_data;
	logic             branch_taken;
	rv_pkg::xlen_t    branch_target;

	rv_pkg::xlen_t    model [0:31]; // Expected register contents.
	logic [15:0]      lfsr;

	rv_exec_top DUT (
		.clock         (clock),
		.reset         (reset),
		.instr_valid   (instr_valid),
		.instr         (instr),
		.pc            (pc),
		.wb_valid      (wb_valid),
		.wb_rd         (wb_rd),
		.wb_data       (wb_data),
		.branch_taken  (branch_taken),
		.branch_target (branch_target)
	);

	always #10 clock = ~clock;

	// ------------------------------------------------------------------------
	// Stimulus helpers
	// ------------------------------------------------------------------------

	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[62:0], lfsr[0]};
			lfsr = lfsr[0] ? (lfsr >> 1) ^ 16'hB400 : lfsr >> 1; // Galois step.
		end
		return v;
	endfunction

	function automatic rv_pkg::xlen_t sext12(input logic [11:0] v);
		return {{52{v[11]}}, v};
	endfunction

	function automatic rv_pkg::xlen_t sext32(input logic [31:0] v);
		return {{32{v[31]}}, v};
	endfunction

	function automatic rv_pkg::instr_t enc_r(input logic [6:0] f7, input rv_pkg::reg_idx_t rs2,
		input rv_pkg::reg_idx_t rs1, input logic [2:0] f3, input rv_pkg::reg_idx_t rd,
		input rv_pkg::opcode_t op);
		return {f7, rs2, rs1, f3, rd, op};
	endfunction

	function automatic rv_pkg::instr_t enc_i(input logic [11:0] imm, input rv_pkg::reg_idx_t rs1,
		input logic [2:0] f3, input rv_pkg::reg_idx_t rd, input rv_pkg::opcode_t op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic rv_pkg::instr_t enc_u(input logic [19:0] imm, input rv_pkg::reg_idx_t rd,
		input rv_pkg::opcode_t op);
		return {imm, rd, op};
	endfunction

	function automatic rv_pkg::instr_t enc_b(input logic [12:0] off, input rv_pkg::reg_idx_t rs2,
		input rv_pkg::reg_idx_t rs1, input logic [2:0] f3);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_pkg::op_branch};
	endfunction

	// Branch outcome by func3.
	function automatic logic branch_expect(input logic [2:0] f3, input rv_pkg::xlen_t a,
		input rv_pkg::xlen_t b);
		case (f3)
			3'b000: return a == b;
			3'b001: return a != b;
			3'b100: return $signed(a) < $signed(b);
			3'b101: return $signed(a) >= $signed(b);
			3'b110: return a < b;
			default: return a >= b;
		endcase
	endfunction

	task automatic check(input logic [63:0] actual, input logic [63:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("ERROR at time %0t: %s: got %h, expected %h", $time, what, actual, expected);
			$display("Finished with errors");
			$fatal(1, "value mismatch");
		end
	endtask

	// One strobe, then wait for write-back.
	task automatic issue(input rv_pkg::instr_t word, input rv_pkg::xlen_t addr);
		int waited;
		waited = 0;
		@(posedge clock);
		#1;
		instr_valid = 1'b1;
		instr = word;
		pc = addr;
		@(posedge clock);
		#1;
		instr_valid = 1'b0;
		while (!wb_valid) begin
			if (waited == 20) begin
				$display("Timed out waiting for wb_valid after an instruction strobe");
				$display("Finished with errors");
				$fatal(1, "write-back timeout");
			end else begin
				waited++;
				@(posedge clock);
				#1;
			end
		end
	endtask

	task automatic expect_write(input rv_pkg::instr_t word, input rv_pkg::reg_idx_t rd,
		input rv_pkg::xlen_t value, input string what);
		issue(word, 64'h1000);
		check(64'(wb_rd), 64'(rd), what);
		check(wb_data, value, what);
		check(64'(branch_taken), 64'd0, what);
		if (rd != 5'd0) begin
			model[rd] = value;
		end
	endtask

	task automatic load_const(input rv_pkg::reg_idx_t rd, input logic [19:0] u,
		input logic [11:0] i);
		expect_write(enc_u(u, rd, rv_pkg::op_lui), rd, sext32({u, 12'b0}), "LUI setup");
		expect_write(enc_i(i, rd, 3'b000, rd, rv_pkg::op_op_imm), rd,
			sext32({u, 12'b0}) + sext12(i), "ADDI setup");
	endtask

	// ------------------------------------------------------------------------
	// Tests
	// ------------------------------------------------------------------------

	task automatic test_reset();
		check(64'(wb_valid), 64'd0, "wb_valid after reset");
		check(64'(branch_taken), 64'd0, "branch_taken after reset");
		for (int r = 0; r < 32; r++) begin
			expect_write(enc_r(7'd0, 5'd0, 5'(r), 3'b000, 5'(r), rv_pkg::op_op), 5'(r), 64'd0,
				"register after reset");
		end
	endtask

	task automatic test_imm();
		rv_pkg::xlen_t a;
		logic [11:0]   imm;
		logic [5:0]    sh;
		load_const(5'd1, 20'(rand_bits(20)), 12'(rand_bits(12)));
		a = model[1];
		imm = 12'(rand_bits(12));
		sh = 6'(rand_bits(6));
		expect_write(enc_i(imm, 5'd1, 3'b000, 5'd2, rv_pkg::op_op_imm), 5'd2, a + sext12(imm), "ADDI");
		expect_write(enc_i(imm, 5'd1, 3'b100, 5'd3, rv_pkg::op_op_imm), 5'd3, a ^ sext12(imm), "XORI");
		expect_write(enc_i(imm, 5'd1, 3'b110, 5'd4, rv_pkg::op_op_imm), 5'd4, a | sext12(imm), "ORI");
		expect_write(enc_i(imm, 5'd1, 3'b111, 5'd5, rv_pkg::op_op_imm), 5'd5, a & sext12(imm), "ANDI");
		expect_write(enc_i(imm, 5'd1, 3'b010, 5'd6, rv_pkg::op_op_imm), 5'd6,
			($signed(a) < $signed(sext12(imm))) ? 64'd1 : 64'd0, "SLTI");
		expect_write(enc_i(imm, 5'd1, 3'b011, 5'd7, rv_pkg::op_op_imm), 5'd7,
			(a < sext12(imm)) ? 64'd1 : 64'd0, "SLTIU");
		expect_write(enc_i({6'b000000, sh}, 5'd1, 3'b001, 5'd2, rv_pkg::op_op_imm), 5'd2, a << sh,
			"SLLI");
		expect_write(enc_i({6'b000000, sh}, 5'd1, 3'b101, 5'd3, rv_pkg::op_op_imm), 5'd3, a >> sh,
			"SRLI");
		expect_write(enc_i({6'b010000, sh}, 5'd1, 3'b101, 5'd4, rv_pkg::op_op_imm), 5'd4,
			$signed(a) >>> sh, "SRAI");
		expect_write(enc_i(imm, 5'd1, 3'b000, 5'd0, rv_pkg::op_op_imm), 5'd0, a + sext12(imm),
			"ADDI to x0");
		expect_write(enc_r(7'd0, 5'd0, 5'd0, 3'b000, 5'd6, rv_pkg::op_op), 5'd6, 64'd0, "x0 read");
	endtask

	task automatic test_reg();
		rv_pkg::xlen_t a;
		rv_pkg::xlen_t b;
		load_const(5'd10, 20'(rand_bits(20)), 12'(rand_bits(12)));
		load_const(5'd11, 20'h7FFFF, 12'h7FF);
		a = model[10];
		b = model[11];
		expect_write(enc_r(7'h00, 5'd11, 5'd10, 3'b000, 5'd12, rv_pkg::op_op), 5'd12, a + b, "ADD");
		expect_write(enc_r(7'h20, 5'd11, 5'd10, 3'b000, 5'd12, rv_pkg::op_op), 5'd12, a - b, "SUB");
		expect_write(enc_r(7'h00, 5'd11, 5'd10, 3'b001, 5'd12, rv_pkg::op_op), 5'd12,
			a << b[5:0], "SLL");
		expect_write(enc_r(7'h00, 5'd11, 5'd10, 3'b101, 5'd12, rv_pkg::op_op), 5'd12,
			a >> b[5:0], "SRL");
		expect_write(enc_r(7'h20, 5'd11, 5'd10, 3'b101, 5'd12, rv_pkg::op_op), 5'd12,
			$signed(a) >>> b[5:0], "SRA");
		expect_write(enc_r(7'h00, 5'd11, 5'd10, 3'b010, 5'd12, rv_pkg::op_op), 5'd12,
			($signed(a) < $signed(b)) ? 64'd1 : 64'd0, "SLT");
		expect_write(enc_r(7'h00, 5'd11, 5'd10, 3'b011, 5'd12, rv_pkg::op_op), 5'd12,
			(a < b) ? 64'd1 : 64'd0, "SLTU");
		expect_write(enc_r(7'h00, 5'd11, 5'd10, 3'b000, 5'd13, rv_pkg::op_op_32), 5'd13,
			sext32(a[31:0] + b[31:0]), "ADDW");
		expect_write(enc_r(7'h20, 5'd11, 5'd10, 3'b000, 5'd13, rv_pkg::op_op_32), 5'd13,
			sext32(a[31:0] - b[31:0]), "SUBW");
		expect_write(enc_r(7'h00, 5'd11, 5'd10, 3'b001, 5'd13, rv_pkg::op_op_32), 5'd13,
			sext32(a[31:0] << b[4:0]), "SLLW");
		expect_write(enc_r(7'h00, 5'd11, 5'd11, 3'b000, 5'd13, rv_pkg::op_op_32), 5'd13,
			sext32(b[31:0] + b[31:0]), "ADDW negative");
		check(64'(wb_data[63:32]), 64'(32'hFFFF_FFFF), "ADDW sign extension");
	endtask

	task automatic test_back_to_back();
		rv_pkg::instr_t words [4];
		rv_pkg::xlen_t  results [4];
		logic [11:0]    imm;
		imm = 12'(rand_bits(12));
		words[0] = enc_i(imm, 5'd1, 3'b000, 5'd20, rv_pkg::op_op_imm);
		words[1] = enc_r(7'h00, 5'd20, 5'd20, 3'b000, 5'd21, rv_pkg::op_op);
		words[2] = enc_r(7'h00, 5'd20, 5'd21, 3'b100, 5'd22, rv_pkg::op_op);
		words[3] = enc_r(7'h20, 5'd21, 5'd22, 3'b000, 5'd23, rv_pkg::op_op);
		results[0] = model[1] + sext12(imm);
		results[1] = results[0] + results[0];
		results[2] = results[1] ^ results[0];
		results[3] = results[2] - results[1];
		@(posedge clock);
		#1;
		for (int i = 0; i < 4; i++) begin
			instr_valid = 1'b1;
			instr = words[i];
			pc = 64'h2000 + 64'(4 * i);
			@(posedge clock);
			#1;
			check(64'(wb_valid), 64'd1, "back-to-back wb_valid");
			check(wb_data, results[i], "back-to-back wb_data");
			model[20 + i] = results[i];
		end
		instr_valid = 1'b0;
	endtask

	task automatic test_control();
		logic [19:0]      u;
		logic [11:0]      r;
		logic [20:0]      j_off;
		logic [12:0]      b_off;
		rv_pkg::reg_idx_t rs_a [3];
		rv_pkg::reg_idx_t rs_b [3];
		rs_a = '{5'd14, 5'd15, 5'd15};
		rs_b = '{5'd15, 5'd14, 5'd16};
		u = 20'(rand_bits(20));
		expect_write(enc_u(u, 5'd7, rv_pkg::op_lui), 5'd7, sext32({u, 12'b0}), "LUI");
		expect_write(enc_u(u, 5'd8, rv_pkg::op_auipc), 5'd8, 64'h1000 + sext32({u, 12'b0}),
			"AUIPC");
		r = 12'(rand_bits(12));
		j_off = {{8{r[11]}}, r, 1'b0};
		issue({j_off[20], j_off[10:1], j_off[11], j_off[19:12], 5'd1, rv_pkg::op_jal}, 64'h3000);
		check(64'(wb_rd), 64'd1, "JAL rd");
		check(wb_data, 64'h3004, "JAL link");
		check(64'(branch_taken), 64'd1, "JAL taken");
		check(branch_target, 64'h3000 + {{43{j_off[20]}}, j_off}, "JAL target");
		model[1] = 64'h3004;
		r = 12'(rand_bits(12));
		issue(enc_i(r, 5'd10, 3'b000, 5'd9, rv_pkg::op_jalr), 64'h3100);
		check(wb_data, 64'h3104, "JALR link");
		check(64'(branch_taken), 64'd1, "JALR taken");
		check(branch_target, (model[10] + sext12(r)) & ~64'd1, "JALR target");
		model[9] = 64'h3104;
		load_const(5'd14, 20'hFFFFF, 12'hFFB); // Negative operand.
		load_const(5'd15, 20'h00000, 12'h003);
		load_const(5'd16, 20'h00000, 12'h003);
		for (int f3 = 0; f3 < 8; f3++) begin
			if (f3 == 2 || f3 == 3) continue;
			for (int p = 0; p < 3; p++) begin
				b_off = {12'(rand_bits(12)), 1'b0};
				issue(enc_b(b_off, rs_b[p], rs_a[p], 3'(f3)), 64'h4000);
				check(64'(branch_taken),
					64'(branch_expect(3'(f3), model[rs_a[p]], model[rs_b[p]])), "branch taken");
				check(branch_target, 64'h4000 + {{51{b_off[12]}}, b_off}, "branch target");
				check(64'(wb_rd), 64'd0, "branch rd");
			end
		end
	endtask

	task automatic test_mul_store();
		rv_pkg::xlen_t a;
		rv_pkg::xlen_t b;
		load_const(5'd10, 20'(rand_bits(20)), 12'(rand_bits(12)));
		load_const(5'd11, 20'(rand_bits(20)), 12'(rand_bits(12)));
		a = model[10];
		b = model[11];
		expect_write(enc_r(7'h01, 5'd11, 5'd10, 3'b000, 5'd17, rv_pkg::op_op), 5'd17, a * b, "MUL");
		expect_write(enc_r(7'h01, 5'd11, 5'd10, 3'b000, 5'd18, rv_pkg::op_op_32), 5'd18,
			sext32(a[31:0] * b[31:0]), "MULW");
		check(64'(wb_data[63:32]), 64'({32{model[18][31]}}), "MULW sign extension");
		// SD whose low offset bits sit where rd would be, pointing at x17.
		issue({7'd0, 5'd11, 5'd10, 3'b011, 5'd17, rv_pkg::op_store}, 64'h1000);
		check(64'(wb_rd), 64'd0, "store rd");
		expect_write(enc_r(7'h00, 5'd0, 5'd17, 3'b000, 5'd19, rv_pkg::op_op), 5'd19, model[17],
			"register after store");
	endtask

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		instr_valid = 1'b0;
		instr = '0;
		pc = '0;
		lfsr = 16'd62653;
		for (int r = 0; r < 32; r++) begin
			model[r] = '0;
		end
		repeat (5) @(posedge clock);
		#1;
		reset = 1'b0;
		test_reset();
		test_imm();
		test_reg();
		test_back_to_back();
		test_control();
		test_mul_store();
		$display("Finished with no errors");
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
rv_pkg.sv
rv_decode.sv
rv_regfile.sv
rv_execute.sv
rv_exec_top.sv
tb_rv_exec.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := tb_rv_exec
FILELIST  := tb.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Finished with no errors

SOURCES   := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
